/* vlog.f */
hdl/dram_geom_pkg.sv
hdl/dram_cmd_pkg.sv
hdl/req_fifo.sv
hdl/bank_queues.sv
hdl/cmd_select.sv
hdl/bank_tracker.sv
hdl/dram_scheduler.sv
sim/tb_dram_scheduler.sv

/* Bender.yml */
package:
  name: dram_scheduler

sources:
  - hdl/dram_geom_pkg.sv
  - hdl/dram_cmd_pkg.sv
  - hdl/req_fifo.sv
  - hdl/bank_queues.sv
  - hdl/cmd_select.sv
  - hdl/bank_tracker.sv
  - hdl/dram_scheduler.sv
  - target: simulation
    files:
      - sim/tb_dram_scheduler.sv

/* sim/tb_dram_scheduler.sv */
// Default geometry only and the bank state is modelled from the commands the DUT emits
module tb_dram_scheduler
    import dram_geom_pkg::*;
    import dram_cmd_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BANKS = DEF_BANK_GROUPS * DEF_BANKS_PER_GROUP;
    localparam int GRP_W = $clog2(DEF_BANK_GROUPS);
    localparam int BNK_W = $clog2(DEF_BANKS_PER_GROUP);
    localparam int IDX_W = $clog2(BANKS);
    localparam int ROW_BITS = DEF_ROW_BITS;
    localparam int COL_BITS = DEF_COL_BITS;
    localparam int DATA_BITS = DEF_DATA_BITS;

    typedef struct packed {
        logic [IDX_W-1:0]     bank;
        logic                 write;
        logic [ROW_BITS-1:0]  row;
        logic [COL_BITS-1:0]  col;
        logic [DATA_BITS-1:0] val;
    } req_t;

    logic                 clk_in;
    logic                 rst_in;
    logic [GRP_W-1:0]     bank_group_in;
    logic [BNK_W-1:0]     bank_in;
    logic [ROW_BITS-1:0]  row_in;
    logic [COL_BITS-1:0]  col_in;
    logic [DATA_BITS-1:0] val_in;
    logic                 write_in;
    logic                 valid_in;
    logic                 cmd_ready;
    logic [GRP_W-1:0]     bank_group_out;
    logic [BNK_W-1:0]     bank_out;
    logic [ROW_BITS-1:0]  row_out;
    logic [COL_BITS-1:0]  col_out;
    logic [DATA_BITS-1:0] val_out;
    dram_cmd_e            cmd_out;
    logic                 valid_out;

    req_t                pend[$];                 // Requests not yet served, in arrival order
    logic                model_open[BANKS];
    logic [ROW_BITS-1:0] model_row[BANKS];
    int                  ready_at[BANKS];         // First cycle a bank may take a command
    int                  cycle;
    int                  cmd_cnt;
    int                  done_cnt;
    logic [ROW_BITS-1:0] hit_row;

    dram_scheduler u_dut (.*);

    always #5 clk_in = ~clk_in;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp));
        end
    endtask

    // Oldest pending request of the bank decides which command is legal
    task automatic check_cmd();
        int        b;
        int        idx;
        req_t      r;
        dram_cmd_e exp_cmd;
        b = int'(bank_group_out) * DEF_BANKS_PER_GROUP + int'(bank_out);
        idx = -1;
        for (int i = pend.size() - 1; i >= 0; i--) begin
            if (pend[i].bank == b) begin
                idx = i;
            end
        end
        cmd_cnt++;
        if (idx < 0) begin
            fail_run($sformatf("command on bank %0d while it has no request queued", b));
        end else if (cycle < ready_at[b]) begin
            fail_run($sformatf("command on bank %0d before its latency ran out", b));
        end else begin
            r = pend[idx];
            if (!model_open[b]) begin
                exp_cmd = CMD_ACTIVATE;
            end else if (model_row[b] != r.row) begin
                exp_cmd = CMD_PRECHARGE;
            end else begin
                exp_cmd = r.write ? CMD_WRITE : CMD_READ;
            end
            check_eq("cmd_out", cmd_out, exp_cmd);
            check_eq("row_out", row_out, r.row);
            if (exp_cmd == CMD_ACTIVATE) begin
                model_open[b] = 1'b1;
                model_row[b] = r.row;
                ready_at[b] = cycle + DEF_ACT_LATENCY;
            end else if (exp_cmd == CMD_PRECHARGE) begin
                model_open[b] = 1'b0;
                ready_at[b] = cycle + DEF_PRE_LATENCY;
            end else begin
                check_eq("col_out", col_out, r.col);
                check_eq("val_out", val_out, r.write ? r.val : '0);
                pend.delete(idx);                 // Request served
                done_cnt++;
            end
        end
    endtask

    // Inputs change and outputs are read 1 ns after the edge
    task automatic tick();
        @(posedge clk_in);
        #1;
        cycle++;
        if (valid_out) begin
            check_cmd();
        end
    endtask

    task automatic send_req(input int b, input logic [ROW_BITS-1:0] row, input logic write);
        req_t r;
        r.bank = IDX_W'(b);
        r.write = write;
        r.row = row;
        r.col = COL_BITS'($urandom);
        r.val = {$urandom, $urandom};
        bank_group_in = GRP_W'(b / DEF_BANKS_PER_GROUP);
        bank_in = BNK_W'(b % DEF_BANKS_PER_GROUP);
        row_in = r.row;
        col_in = r.col;
        val_in = r.val;
        write_in = write;
        valid_in = 1'b1;
        pend.push_back(r);
        tick();
        valid_in = 1'b0;
    endtask

    function automatic int pending_on(input int b);
        int n;
        n = 0;
        foreach (pend[i]) begin
            if (pend[i].bank == b) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic wait_done(input int target);
        int waited;
        waited = 0;
        while (done_cnt < target && waited < 600) begin
            tick();
            waited++;
        end
        if (done_cnt < target) begin
            fail_run("timeout while waiting for a READ or WRITE on valid_out");
        end
    endtask

    task automatic test_idle();
        check_eq("valid_out", valid_out, 0);
        check_eq("cmd_out", cmd_out, CMD_READ);
        check_eq("bank_group_out", bank_group_out, 0);
        check_eq("bank_out", bank_out, 0);
        check_eq("row_out", row_out, 0);
        check_eq("col_out", col_out, 0);
        check_eq("val_out", val_out, 0);
        repeat (20) begin
            tick();
            check_eq("valid_out", valid_out, 0);
        end
    endtask

    task automatic test_access(input int b, input logic [ROW_BITS-1:0] row, input logic write,
                               input int exp_cmds);
        int start;
        int target;
        start = cmd_cnt;
        target = done_cnt + 1;
        send_req(b, row, write);
        wait_done(target);
        check_eq("command count", cmd_cnt - start, exp_cmds);
    endtask

    task automatic test_backpressure();
        int target;
        target = done_cnt + 3;
        cmd_ready = 1'b0;
        send_req(0, ROW_BITS'($urandom), 1'b1);
        send_req(1, ROW_BITS'($urandom), 1'b0);
        send_req(3, ROW_BITS'($urandom), 1'b1);
        repeat (30) begin
            tick();
            check_eq("valid_out", valid_out, 0);
        end
        cmd_ready = 1'b1;
        wait_done(target);
    endtask

    task automatic test_random();
        int target;
        int b;
        target = done_cnt;
        for (int k = 0; k < 16; k++) begin
            b = $urandom_range(BANKS - 1);
            if (pending_on(b) < DEF_QUEUE_DEPTH - 1) begin   // Stay below the FIFO depth
                send_req(b, ROW_BITS'($urandom_range(3)), 1'($urandom));
                target++;
            end else begin
                tick();
            end
        end
        wait_done(target);
        repeat (20) begin                         // Nothing left to issue
            tick();
            check_eq("valid_out", valid_out, 0);
        end
    endtask

    initial begin
        void'($urandom(34718));
        clk_in = 1'b0;
        rst_in = 1'b1;
        bank_group_in = '0;
        bank_in = '0;
        row_in = '0;
        col_in = '0;
        val_in = '0;
        write_in = 1'b0;
        valid_in = 1'b0;
        cmd_ready = 1'b1;
        cycle = 0;
        cmd_cnt = 0;
        done_cnt = 0;
        foreach (model_open[b]) begin
            model_open[b] = 1'b0;
            model_row[b] = '0;
            ready_at[b] = 0;
        end
        repeat (8) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
        hit_row = ROW_BITS'($urandom);
        test_idle();
        test_access(2, hit_row, 1'b0, 2);             // ACTIVATE then READ
        test_access(2, hit_row, 1'b1, 1);             // Row hit
        test_access(2, hit_row ^ ROW_BITS'(8'h5a), 1'($urandom), 3);
        test_backpressure();
        test_random();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* hdl/dram_scheduler.sv */
// Single rank and requests to a bank whose FIFO is full are dropped since there is no ready
module dram_scheduler
    import dram_geom_pkg::*;
    import dram_cmd_pkg::*;
#(
    parameter int BANK_GROUPS = DEF_BANK_GROUPS,
    parameter int BANKS_PER_GROUP = DEF_BANKS_PER_GROUP,
    parameter int ROW_BITS = DEF_ROW_BITS,
    parameter int COL_BITS = DEF_COL_BITS,
    parameter int DATA_BITS = DEF_DATA_BITS,
    parameter int QUEUE_DEPTH = DEF_QUEUE_DEPTH,
    parameter int ACT_LATENCY = DEF_ACT_LATENCY,
    parameter int PRE_LATENCY = DEF_PRE_LATENCY,
    localparam int BANKS = BANK_GROUPS * BANKS_PER_GROUP,
    localparam int GRP_BITS = field_bits(BANK_GROUPS),
    localparam int BNK_BITS = field_bits(BANKS_PER_GROUP),
    localparam int IDX_BITS = field_bits(BANKS)
) (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic [GRP_BITS-1:0]  bank_group_in,
    input  logic [BNK_BITS-1:0]  bank_in,
    input  logic [ROW_BITS-1:0]  row_in,
    input  logic [COL_BITS-1:0]  col_in,
    input  logic [DATA_BITS-1:0] val_in,
    input  logic                 write_in,
    input  logic                 valid_in,
    input  logic                 cmd_ready,
    output logic [GRP_BITS-1:0]  bank_group_out,
    output logic [BNK_BITS-1:0]  bank_out,
    output logic [ROW_BITS-1:0]  row_out,
    output logic [COL_BITS-1:0]  col_out,
    output logic [DATA_BITS-1:0] val_out,
    output dram_cmd_e            cmd_out,
    output logic                 valid_out
);
    logic [BANKS-1:0][ROW_BITS-1:0]  head_row;
    logic [BANKS-1:0][COL_BITS-1:0]  head_col;
    logic [BANKS-1:0][DATA_BITS-1:0] head_val;
    logic [BANKS-1:0]                head_write;
    logic [BANKS-1:0]                empty;
    logic [BANKS-1:0]                pop;
    logic                            issue;
    dram_cmd_e                       issue_cmd;
    logic [IDX_BITS-1:0]             issue_bank;
    logic [ROW_BITS-1:0]             issue_row;
    logic [BANKS-1:0][ROW_BITS-1:0]  open_row;
    logic [BANKS-1:0]                row_open;
    logic [BANKS-1:0]                busy;

    bank_queues #(
        .BANK_GROUPS(BANK_GROUPS),
        .BANKS_PER_GROUP(BANKS_PER_GROUP),
        .ROW_BITS(ROW_BITS),
        .COL_BITS(COL_BITS),
        .DATA_BITS(DATA_BITS),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queues (
        .clk_in,
        .rst_in,
        .bank_group_in,
        .bank_in,
        .row_in,
        .col_in,
        .val_in,
        .write_in,
        .valid_in,
        .pop,
        .head_row,
        .head_col,
        .head_val,
        .head_write,
        .empty
    );

    cmd_select #(
        .BANK_GROUPS(BANK_GROUPS),
        .BANKS_PER_GROUP(BANKS_PER_GROUP),
        .ROW_BITS(ROW_BITS),
        .COL_BITS(COL_BITS),
        .DATA_BITS(DATA_BITS)
    ) u_select (
        .clk_in,
        .rst_in,
        .head_row,
        .head_col,
        .head_val,
        .head_write,
        .empty,
        .open_row,
        .row_open,
        .busy,
        .cmd_ready,
        .pop,
        .issue,
        .issue_cmd,
        .issue_bank,
        .issue_row,
        .bank_group_out,
        .bank_out,
        .row_out,
        .col_out,
        .val_out,
        .cmd_out,
        .valid_out
    );

    bank_tracker #(
        .BANK_GROUPS(BANK_GROUPS),
        .BANKS_PER_GROUP(BANKS_PER_GROUP),
        .ROW_BITS(ROW_BITS),
        .ACT_LATENCY(ACT_LATENCY),
        .PRE_LATENCY(PRE_LATENCY)
    ) u_tracker (
        .clk_in,
        .rst_in,
        .issue,
        .issue_cmd,
        .issue_bank,
        .issue_row,
        .open_row,
        .row_open,
        .busy
    );

endmodule

/* hdl/bank_tracker.sv */
// Latencies must be at least 1 and countdowns keep running while issue is paused
module bank_tracker
    import dram_geom_pkg::*;
    import dram_cmd_pkg::*;
#(
    parameter int BANK_GROUPS = DEF_BANK_GROUPS,
    parameter int BANKS_PER_GROUP = DEF_BANKS_PER_GROUP,
    parameter int ROW_BITS = DEF_ROW_BITS,
    parameter int ACT_LATENCY = DEF_ACT_LATENCY,
    parameter int PRE_LATENCY = DEF_PRE_LATENCY,
    localparam int BANKS = BANK_GROUPS * BANKS_PER_GROUP,
    localparam int IDX_BITS = field_bits(BANKS),
    localparam int MAX_LATENCY = (ACT_LATENCY > PRE_LATENCY) ? ACT_LATENCY : PRE_LATENCY,
    localparam int CNT_BITS = $clog2(MAX_LATENCY + 1)
) (
    input  logic                           clk_in,
    input  logic                           rst_in,
    input  logic                           issue,
    input  dram_cmd_e                      issue_cmd,
    input  logic [IDX_BITS-1:0]            issue_bank,
    input  logic [ROW_BITS-1:0]            issue_row,
    output logic [BANKS-1:0][ROW_BITS-1:0] open_row,
    output logic [BANKS-1:0]               row_open,
    output logic [BANKS-1:0]               busy
);
    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        logic                sel;
        logic                is_open;
        logic [ROW_BITS-1:0] row;
        logic [CNT_BITS-1:0] count;

        assign sel = issue && (issue_bank == IDX_BITS'(b));

        always_ff @(posedge clk_in or posedge rst_in) begin
            if (rst_in) begin
                is_open <= 1'b0;                  // Banks start precharged
                count <= '0;
            end else if (sel && issue_cmd == CMD_ACTIVATE) begin
                is_open <= 1'b1;
                count <= CNT_BITS'(ACT_LATENCY);
            end else if (sel && issue_cmd == CMD_PRECHARGE) begin
                is_open <= 1'b0;
                count <= CNT_BITS'(PRE_LATENCY);
            end else if (count != '0) begin
                count <= count - 1'b1;
            end
        end

        always_ff @(posedge clk_in) begin
            if (sel && issue_cmd == CMD_ACTIVATE) begin
                row <= issue_row;                 // Only meaningful while is_open
            end
        end

        assign open_row[b] = row;
        assign row_open[b] = is_open;
        assign busy[b] = (count != '0);
    end

    assert property (@(posedge clk_in) disable iff (rst_in) issue |-> !busy[issue_bank])
        else $error("command issued to a busy bank");

    // Column commands only reach the row that the bank holds open
    assert property (@(posedge clk_in) disable iff (rst_in)
        issue && is_rw(issue_cmd) |-> row_open[issue_bank] && open_row[issue_bank] == issue_row)
        else $error("READ or WRITE issued without its row open");

endmodule

/* hdl/cmd_select.sv */
// One command per cycle with row hits first, then activates, then precharges, lowest bank wins
module cmd_select
    import dram_geom_pkg::*;
    import dram_cmd_pkg::*;
#(
    parameter int BANK_GROUPS = DEF_BANK_GROUPS,
    parameter int BANKS_PER_GROUP = DEF_BANKS_PER_GROUP,
    parameter int ROW_BITS = DEF_ROW_BITS,
    parameter int COL_BITS = DEF_COL_BITS,
    parameter int DATA_BITS = DEF_DATA_BITS,
    localparam int BANKS = BANK_GROUPS * BANKS_PER_GROUP,
    localparam int GRP_BITS = field_bits(BANK_GROUPS),
    localparam int BNK_BITS = field_bits(BANKS_PER_GROUP),
    localparam int IDX_BITS = field_bits(BANKS)
) (
    input  logic                            clk_in,
    input  logic                            rst_in,
    input  logic [BANKS-1:0][ROW_BITS-1:0]  head_row,
    input  logic [BANKS-1:0][COL_BITS-1:0]  head_col,
    input  logic [BANKS-1:0][DATA_BITS-1:0] head_val,
    input  logic [BANKS-1:0]                head_write,
    input  logic [BANKS-1:0]                empty,
    input  logic [BANKS-1:0][ROW_BITS-1:0]  open_row,
    input  logic [BANKS-1:0]                row_open,
    input  logic [BANKS-1:0]                busy,
    input  logic                            cmd_ready,
    output logic [BANKS-1:0]                pop,
    output logic                            issue,
    output dram_cmd_e                       issue_cmd,
    output logic [IDX_BITS-1:0]             issue_bank,
    output logic [ROW_BITS-1:0]             issue_row,
    output logic [GRP_BITS-1:0]             bank_group_out,
    output logic [BNK_BITS-1:0]             bank_out,
    output logic [ROW_BITS-1:0]             row_out,
    output logic [COL_BITS-1:0]             col_out,
    output logic [DATA_BITS-1:0]            val_out,
    output dram_cmd_e                       cmd_out,
    output logic                            valid_out
);
    logic [BANKS-1:0] row_hit;
    logic [1:0]       best_rank;

    for (genvar b = 0; b < BANKS; b++) begin : g_hit
        assign row_hit[b] = row_open[b] && (open_row[b] == head_row[b]);
    end

    // Rank 3 is a row hit, 2 an activate, 1 a precharge and 0 means no candidate
    always_comb begin
        logic [1:0] rank;
        dram_cmd_e  cand_cmd;
        best_rank = 2'd0;
        issue_bank = '0;
        issue_cmd = CMD_READ;
        for (int b = 0; b < BANKS; b++) begin
            if (row_hit[b]) begin
                rank = 2'd3;
                cand_cmd = head_write[b] ? CMD_WRITE : CMD_READ;
            end else if (!row_open[b]) begin
                rank = 2'd2;
                cand_cmd = CMD_ACTIVATE;
            end else begin
                rank = 2'd1;
                cand_cmd = CMD_PRECHARGE;
            end
            if (!empty[b] && !busy[b] && rank > best_rank) begin   // Strict so lower bank keeps it
                best_rank = rank;
                issue_bank = IDX_BITS'(b);
                issue_cmd = cand_cmd;
            end
        end
    end

    assign issue = (best_rank != 2'd0) && cmd_ready;
    assign issue_row = head_row[issue_bank];

    always_comb begin
        pop = '0;
        if (issue && is_rw(issue_cmd)) begin
            pop[issue_bank] = 1'b1;               // Request leaves with its column command
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            valid_out <= 1'b0;
            cmd_out <= CMD_READ;
            bank_group_out <= '0;
            bank_out <= '0;
            row_out <= '0;
            col_out <= '0;
            val_out <= '0;
        end else begin
            valid_out <= issue;                   // One pulse per command
            if (issue) begin
                cmd_out <= issue_cmd;
                bank_group_out <= GRP_BITS'(issue_bank / BANKS_PER_GROUP);
                bank_out <= BNK_BITS'(issue_bank % BANKS_PER_GROUP);
                row_out <= issue_row;
                col_out <= head_col[issue_bank];
                val_out <= (issue_cmd == CMD_WRITE) ? head_val[issue_bank] : '0;
            end
        end
    end

    assert property (@(posedge clk_in) disable iff (rst_in) $onehot0(pop))
        else $error("more than one bank FIFO popped in a cycle");

endmodule

/* hdl/bank_queues.sv */
// Bank groups and banks per group must each be at least 2 and the bank index is group-major
module bank_queues
    import dram_geom_pkg::*;
#(
    parameter int BANK_GROUPS = DEF_BANK_GROUPS,
    parameter int BANKS_PER_GROUP = DEF_BANKS_PER_GROUP,
    parameter int ROW_BITS = DEF_ROW_BITS,
    parameter int COL_BITS = DEF_COL_BITS,
    parameter int DATA_BITS = DEF_DATA_BITS,
    parameter int QUEUE_DEPTH = DEF_QUEUE_DEPTH,
    localparam int BANKS = BANK_GROUPS * BANKS_PER_GROUP,
    localparam int GRP_BITS = $clog2(BANK_GROUPS),
    localparam int BNK_BITS = $clog2(BANKS_PER_GROUP),
    localparam int IDX_BITS = $clog2(BANKS)
) (
    input  logic                            clk_in,
    input  logic                            rst_in,
    input  logic [GRP_BITS-1:0]             bank_group_in,
    input  logic [BNK_BITS-1:0]             bank_in,
    input  logic [ROW_BITS-1:0]             row_in,
    input  logic [COL_BITS-1:0]             col_in,
    input  logic [DATA_BITS-1:0]            val_in,
    input  logic                            write_in,
    input  logic                            valid_in,
    input  logic [BANKS-1:0]                pop,
    output logic [BANKS-1:0][ROW_BITS-1:0]  head_row,
    output logic [BANKS-1:0][COL_BITS-1:0]  head_col,
    output logic [BANKS-1:0][DATA_BITS-1:0] head_val,
    output logic [BANKS-1:0]                head_write,
    output logic [BANKS-1:0]                empty
);
    localparam int ENTRY_BITS = ROW_BITS + COL_BITS + DATA_BITS + 1;

    logic [IDX_BITS-1:0]              bank_idx;
    logic [ENTRY_BITS-1:0]            entry;
    logic [BANKS-1:0][ENTRY_BITS-1:0] head_entry;

    assign bank_idx = IDX_BITS'(bank_group_in) * IDX_BITS'(BANKS_PER_GROUP)
                    + IDX_BITS'(bank_in);
    assign entry = {write_in, row_in, col_in, val_in};   // Fixed request layout

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        req_fifo #(
            .DEPTH(QUEUE_DEPTH),
            .WIDTH(ENTRY_BITS)
        ) u_fifo (
            .clk_in,
            .rst_in,
            .push(valid_in && (bank_idx == IDX_BITS'(b))),
            .pop(pop[b]),
            .push_data(entry),
            .head_data(head_entry[b]),
            .empty(empty[b]),
            .full()
        );

        assign {head_write[b], head_row[b], head_col[b], head_val[b]} = head_entry[b];
    end

endmodule

/* hdl/req_fifo.sv */
// DEPTH must be at least 2 and a push into a full FIFO or a pop from an empty one is ignored
module req_fifo
    import dram_geom_pkg::*;
#(
    parameter int DEPTH = DEF_QUEUE_DEPTH,
    parameter int WIDTH = DEF_ROW_BITS + DEF_COL_BITS + DEF_DATA_BITS + 1,
    localparam int PTR_BITS = $clog2(DEPTH),
    localparam int CNT_BITS = $clog2(DEPTH + 1)
) (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] push_data,
    output logic [WIDTH-1:0] head_data,
    output logic             empty,
    output logic             full
);
    logic [WIDTH-1:0]    mem [DEPTH];
    logic [PTR_BITS-1:0] head;
    logic [CNT_BITS-1:0] count;
    logic [CNT_BITS:0]   tail_sum;
    logic [PTR_BITS-1:0] tail;
    logic                do_push;
    logic                do_pop;

    assign empty = (count == '0);
    assign full = (count == CNT_BITS'(DEPTH));
    assign do_push = push && !full;
    assign do_pop = pop && !empty;
    assign head_data = mem[head];

    // Slot behind the last entry, wrapped into the buffer
    assign tail_sum = {1'b0, count} + (CNT_BITS + 1)'(head);
    assign tail = (tail_sum >= DEPTH) ? PTR_BITS'(tail_sum - DEPTH) : PTR_BITS'(tail_sum);

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            head <= '0;
            count <= '0;
        end else begin
            if (do_pop) begin
                head <= (head == PTR_BITS'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            count <= count + CNT_BITS'(do_push) - CNT_BITS'(do_pop);
        end
    end

    always_ff @(posedge clk_in) begin
        if (do_push) begin
            mem[tail] <= push_data;               // Entry shows at the head next cycle if empty
        end
    end

    // A request that meets a full FIFO is lost upstream
    assert property (@(posedge clk_in) disable iff (rst_in) push |-> !full)
        else $error("request pushed into a full bank FIFO and lost");

    assert property (@(posedge clk_in) disable iff (rst_in) pop |-> !empty)
        else $error("pop from an empty bank FIFO");

endmodule

/* hdl/dram_cmd_pkg.sv */
// Command codes follow the controller encoding and field widths never drop below one bit
package dram_cmd_pkg;

    localparam int CMD_BITS = 3;              // Width of the command code

    typedef enum logic [CMD_BITS-1:0] {
        CMD_READ      = 3'd0,
        CMD_WRITE     = 3'd1,
        CMD_ACTIVATE  = 3'd2,
        CMD_PRECHARGE = 3'd3
    } dram_cmd_e;

    // Bits needed to encode an index below count
    function automatic int field_bits(input int count);
        return (count > 1) ? $clog2(count) : 1;
    endfunction

    // Column commands that move data
    function automatic logic is_rw(input dram_cmd_e cmd);
        return (cmd == CMD_READ) || (cmd == CMD_WRITE);
    endfunction

endpackage

/* hdl/dram_geom_pkg.sv */
// Default geometry and timing of one rank, every value can be overridden at the top level
package dram_geom_pkg;

    // Bank geometry
    localparam int DEF_BANK_GROUPS = 2;       // Groups in the rank
    localparam int DEF_BANKS_PER_GROUP = 2;   // Banks in each group

    // Request fields
    localparam int DEF_ROW_BITS = 8;          // Row address width
    localparam int DEF_COL_BITS = 4;          // Column address width
    localparam int DEF_DATA_BITS = 64;        // Write data width

    // Per-bank request FIFO
    localparam int DEF_QUEUE_DEPTH = 4;       // Entries per bank

    // Busy cycles after a row command
    localparam int DEF_ACT_LATENCY = 8;       // Activate to first access
    localparam int DEF_PRE_LATENCY = 5;       // Precharge to next activate

endpackage
